// File: files.f
logic/bridge_pkg.sv
logic/av_pkg.sv
logic/bridge_settings.sv
logic/pad_mapper.sv
logic/video_output_shaper.sv
logic/core_top.sv
testbench/core_top_tb.sv

// File: Makefile
VERILATOR  = verilator
TOP        = core_top_tb
FILELIST   = files.f
BUILD_DIR  = obj_dir
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: testbench/core_top_tests.txt
# columns: name kind a b c, numbers in hex
# write addr data readback | read addr 0 value | reset gap 0 length | pad map_y_b multitap rounds | video hide_overscan active_len 0 | sync is_hsync delay pulse_cycles
rd_hide_at_reset read 200 0 0
rd_pal_at_reset read 20c 0 0
wr_hide_on write 200 ffffffff 1
wr_mask_edges write 204 7 3
wr_extra_sprites write 208 3 1
wr_palette write 20c fffffffd 5
wr_multitap write 300 1 1
wr_map_y_b write 310 1 1
rd_hide read 200 0 1
rd_palette read 20c 0 5
rd_reset_addr read 50 0 0
rd_unmapped read 204c 0 0
wr_unmapped write 400 ffffffff 0
rd_mask_kept read 204 0 3
wr_hide_off write 200 2 0
reset_single reset 0 0 10
reset_extend reset 5 0 15
pad_plain pad 0 1 8
pad_remap pad 1 1 8
pad_no_tap pad 0 0 8
pad_tap_back_on pad 1 1 4
video_hide_off video 0 6 0
video_hide_on video 1 6 0
vsync_pulse sync 0 1 1
hsync_pulse sync 1 7 1

// File: testbench/core_top_tb.sv
// testbench for core_top
// reads one test per line from testbench/core_top_tests.txt and runs it
// covers bridge settings, external reset, pad mapping and video shaping

module core_top_tb
  import bridge_pkg::*;
  import av_pkg::*;
;

  localparam logic [31:0] RESET_HOLD_CYCLES = 32'd16;
  localparam int HS_DELAY = 7;
  localparam int SYNC_STAGES = 3;
  localparam int RESET_TIMEOUT = 200;
  localparam int SYNC_WINDOW = 24;

  logic         clk_74a = 1'b0;
  logic         pll_core_locked;
  bridge_addr_t bridge_addr;
  logic         bridge_wr;
  bridge_data_t bridge_wr_data;
  logic         bridge_rd;
  bridge_data_t bridge_rd_data;
  logic         hide_overscan;
  edge_mask_t   mask_vid_edges;
  logic         allow_extra_sprites;
  palette_t     selected_palette;
  logic         multitap_enabled;
  logic         map_y_b;
  logic         external_reset;
  key_map_t     cont1_key;
  key_map_t     cont2_key;
  key_map_t     cont3_key;
  key_map_t     cont4_key;
  nes_buttons_t p1_buttons;
  nes_buttons_t p2_buttons;
  nes_buttons_t p3_buttons;
  nes_buttons_t p4_buttons;
  logic         core_hblank;
  logic         core_vblank;
  logic         core_hsync;
  logic         core_vsync;
  rgb_t         core_rgb;
  logic         video_de;
  logic         video_hs;
  logic         video_vs;
  rgb_t         video_rgb;

  logic [31:0]  lfsr_state;

  core_top #(
    .RESET_HOLD_CYCLES(RESET_HOLD_CYCLES),
    .HS_DELAY         (HS_DELAY),
    .SYNC_STAGES      (SYNC_STAGES)
  ) i_dut (
    .clk_74a            (clk_74a),
    .pll_core_locked    (pll_core_locked),
    .bridge_addr        (bridge_addr),
    .bridge_wr          (bridge_wr),
    .bridge_wr_data     (bridge_wr_data),
    .bridge_rd          (bridge_rd),
    .bridge_rd_data     (bridge_rd_data),
    .hide_overscan      (hide_overscan),
    .mask_vid_edges     (mask_vid_edges),
    .allow_extra_sprites(allow_extra_sprites),
    .selected_palette   (selected_palette),
    .multitap_enabled   (multitap_enabled),
    .map_y_b            (map_y_b),
    .external_reset     (external_reset),
    .cont1_key          (cont1_key),
    .cont2_key          (cont2_key),
    .cont3_key          (cont3_key),
    .cont4_key          (cont4_key),
    .p1_buttons         (p1_buttons),
    .p2_buttons         (p2_buttons),
    .p3_buttons         (p3_buttons),
    .p4_buttons         (p4_buttons),
    .core_hblank        (core_hblank),
    .core_vblank        (core_vblank),
    .core_hsync         (core_hsync),
    .core_vsync         (core_vsync),
    .core_rgb           (core_rgb),
    .video_de           (video_de),
    .video_hs           (video_hs),
    .video_vs           (video_vs),
    .video_rgb          (video_rgb)
  );

  always #4 clk_74a = ~clk_74a;

  ////////////////////////////////////////
  // failure reporting and compares

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped after a failed check");
  endtask

  task automatic check_data(input string name, input bridge_data_t expected,
                            input bridge_data_t actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("Error: test %s expected %h actual %h",
                                  name, expected, actual));
    end
  endtask

  task automatic check_buttons(input string name, input nes_buttons_t expected,
                               input nes_buttons_t actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("Error: test %s expected %h actual %h",
                                  name, expected, actual));
    end
  endtask

  task automatic check_rgb(input string name, input rgb_t expected, input rgb_t actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("Error: test %s expected %h actual %h",
                                  name, expected, actual));
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("Error: test %s expected %b actual %b",
                                  name, expected, actual));
    end
  endtask

  // cycle counts for reset length and sync delay
  task automatic check_count(input string name, input int expected, input int actual);
    if (actual != expected) begin
      stop_with_failure($sformatf("Error: test %s expected %0d actual %0d",
                                  name, expected, actual));
    end
  endtask

  ////////////////////////////////////////
  // random source

  // galois form with taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h8020_0003;
    end
    return state >> 1;
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] random_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      value = {value[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
    return value;
  endfunction

  // nes byte from bit 0 upward is a, b, select, start, up, down, left, right
  function automatic nes_buttons_t expected_buttons(input key_map_t key, input logic remap,
                                                    input logic enabled);
    nes_buttons_t byte_out;
    byte_out = '0;
    if (enabled) begin
      byte_out[0] = remap ? key[KEY_FACE_B] : key[KEY_FACE_A];
      byte_out[1] = remap ? key[KEY_FACE_Y] : key[KEY_FACE_B];
      byte_out[2] = key[KEY_SELECT];
      byte_out[3] = key[KEY_START];
      byte_out[4] = key[KEY_UP];
      byte_out[5] = key[KEY_DOWN];
      byte_out[6] = key[KEY_LEFT];
      byte_out[7] = key[KEY_RIGHT];
    end
    return byte_out;
  endfunction

  ////////////////////////////////////////
  // bridge access

  // returns on the falling edge after the write edge
  task automatic bridge_write(input bridge_addr_t addr, input bridge_data_t data);
    @(negedge clk_74a);
    bridge_addr    = addr;
    bridge_wr_data = data;
    bridge_wr      = 1'b1;
    @(negedge clk_74a);
    bridge_wr = 1'b0;
  endtask

  task automatic bridge_read(input bridge_addr_t addr, output bridge_data_t data);
    @(negedge clk_74a);
    bridge_addr = addr;
    bridge_rd   = 1'b1;
    @(negedge clk_74a);
    data      = bridge_rd_data;
    bridge_rd = 1'b0;
  endtask

  ////////////////////////////////////////
  // test kinds

  task automatic run_write(input string name, input bridge_addr_t addr,
                           input bridge_data_t data, input bridge_data_t expected);
    bridge_data_t readback;
    bridge_write(addr, data);
    // core setting output matching the address
    case (addr)
      ADDR_HIDE_OVERSCAN: check_data(name, expected, {31'b0, hide_overscan});
      ADDR_MASK_EDGES:    check_data(name, expected, {30'b0, mask_vid_edges});
      ADDR_EXTRA_SPRITES: check_data(name, expected, {31'b0, allow_extra_sprites});
      ADDR_PALETTE:       check_data(name, expected, {29'b0, selected_palette});
      ADDR_MULTITAP:      check_data(name, expected, {31'b0, multitap_enabled});
      ADDR_MAP_Y_B:       check_data(name, expected, {31'b0, map_y_b});
      default:            ;
    endcase
    bridge_read(addr, readback);
    check_data(name, expected, readback);
  endtask

  task automatic run_read(input string name, input bridge_addr_t addr,
                          input bridge_data_t expected);
    bridge_data_t readback;
    bridge_read(addr, readback);
    check_data(name, expected, readback);
  endtask

  // a gap of zero means one write
  // otherwise the write repeats after gap high cycles
  task automatic run_reset(input string name, input int gap, input int expected_len);
    int   count;
    logic done;
    @(negedge clk_74a);
    bridge_addr    = ADDR_RESET;
    bridge_wr_data = '0;
    bridge_wr      = 1'b1;
    count = 0;
    done  = 1'b0;
    while (!done) begin
      @(negedge clk_74a);
      bridge_wr = 1'b0;
      if (!external_reset) begin
        done = 1'b1;
      end else begin
        count++;
        if (gap != 0 && count == gap) begin
          bridge_wr = 1'b1;
        end
        if (count > RESET_TIMEOUT) begin
          stop_with_failure("external_reset did not fall within the timeout");
        end
      end
    end
    check_count(name, expected_len, count);
  endtask

  task automatic run_pad(input string name, input logic remap, input logic tap,
                         input int rounds);
    key_map_t    keys [4];
    key_map_t    prev [4];
    logic [31:0] raw;
    bridge_write(ADDR_MAP_Y_B, {31'b0, remap});
    bridge_write(ADDR_MULTITAP, {31'b0, tap});
    for (int r = 0; r < rounds; r++) begin
      prev[0] = cont1_key;
      prev[1] = cont2_key;
      prev[2] = cont3_key;
      prev[3] = cont4_key;
      for (int p = 0; p < 4; p++) begin
        raw = random_bits(16);
        keys[p] = raw[15:0];
      end
      cont1_key = keys[0];
      cont2_key = keys[1];
      cont3_key = keys[2];
      cont4_key = keys[3];
      // one cycle short of the latency the old keys still show
      repeat (SYNC_STAGES) @(negedge clk_74a);
      check_buttons(name, expected_buttons(prev[0], remap, 1'b1), p1_buttons);
      check_buttons(name, expected_buttons(prev[1], 1'b0, 1'b1), p2_buttons);
      check_buttons(name, expected_buttons(prev[2], 1'b0, tap), p3_buttons);
      check_buttons(name, expected_buttons(prev[3], 1'b0, tap), p4_buttons);
      // synchronizer stages plus the button register
      @(negedge clk_74a);
      check_buttons(name, expected_buttons(keys[0], remap, 1'b1), p1_buttons);
      check_buttons(name, expected_buttons(keys[1], 1'b0, 1'b1), p2_buttons);
      check_buttons(name, expected_buttons(keys[2], 1'b0, tap), p3_buttons);
      check_buttons(name, expected_buttons(keys[3], 1'b0, tap), p4_buttons);
    end
  endtask

  // three hblank cycles, active_len pixels, four vblank cycles
  task automatic run_video(input string name, input logic hide, input int active_len);
    int          total;
    logic        active;
    logic        prev_active;
    logic [31:0] raw;
    rgb_t        pixel;
    rgb_t        slot;
    rgb_t        expected;
    bridge_write(ADDR_HIDE_OVERSCAN, {31'b0, hide});
    slot        = hide ? 24'h00_2000 : 24'h00_0000;
    prev_active = 1'b0;
    total       = active_len + 7;
    for (int i = 0; i < total; i++) begin
      active = (i >= 3) && (i < 3 + active_len);
      raw    = random_bits(24);
      pixel  = raw[23:0];
      core_hblank = !active && (i < 3);
      core_vblank = !active && (i >= 3);
      core_rgb    = pixel;
      @(negedge clk_74a);
      check_bit(name, active, video_de);
      if (active) begin
        expected = pixel;
      end else if (prev_active) begin
        expected = slot;
      end else begin
        expected = '0;
      end
      check_rgb(name, expected, video_rgb);
      prev_active = active;
    end
    core_hblank = 1'b1;
    core_vblank = 1'b0;
    core_rgb    = '0;
  endtask

  // use_hsync picks the sync line
  // the chosen input stays high for three cycles
  task automatic run_sync(input string name, input logic use_hsync, input int expected_delay,
                          input int expected_cycles);
    int   first;
    int   high;
    logic pulse;
    @(negedge clk_74a);
    if (use_hsync) begin
      core_hsync = 1'b1;
    end else begin
      core_vsync = 1'b1;
    end
    first = 0;
    high  = 0;
    for (int cycle = 1; cycle <= SYNC_WINDOW; cycle++) begin
      @(negedge clk_74a);
      if (cycle == 3) begin
        core_hsync = 1'b0;
        core_vsync = 1'b0;
      end
      pulse = use_hsync ? video_hs : video_vs;
      if (pulse) begin
        high++;
        if (first == 0) begin
          first = cycle;
        end
      end
    end
    if (first == 0) begin
      stop_with_failure($sformatf("no sync pulse seen within %0d cycles in test %s",
                                  SYNC_WINDOW, name));
    end
    check_count(name, expected_delay, first);
    check_count(name, expected_cycles, high);
  endtask

  ////////////////////////////////////////
  // main sequence

  initial begin
    int          fd;
    int          got;
    int          fields;
    int          tests_run;
    string       line;
    string       name;
    string       kind;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;

    pll_core_locked = 1'b0;
    bridge_addr     = '0;
    bridge_wr       = 1'b0;
    bridge_wr_data  = '0;
    bridge_rd       = 1'b0;
    cont1_key       = '0;
    cont2_key       = '0;
    cont3_key       = '0;
    cont4_key       = '0;
    core_hblank     = 1'b1;
    core_vblank     = 1'b0;
    core_hsync      = 1'b0;
    core_vsync      = 1'b0;
    core_rgb        = '0;
    lfsr_state      = 32'ha96215a3;
    tests_run       = 0;

    repeat (5) @(negedge clk_74a);
    pll_core_locked = 1'b1;

    fd = $fopen("testbench/core_top_tests.txt", "r");
    if (fd == 0) begin
      stop_with_failure("could not open testbench/core_top_tests.txt");
    end

    while (!$feof(fd)) begin
      line = "";
      got  = $fgets(line, fd);
      // blank lines and # comments carry no test
      if (got != 0 && line.len() > 1 && line.getc(0) != "#") begin
        fields = $sscanf(line, "%s %s %h %h %h", name, kind, a, b, c);
        if (fields != 5) begin
          stop_with_failure($sformatf("malformed test line: %s", line));
        end
        case (kind)
          "write": run_write(name, a, b, c);
          "read":  run_read(name, a, c);
          "reset": run_reset(name, a, c);
          "pad":   run_pad(name, a[0], b[0], c);
          "video": run_video(name, a[0], b);
          "sync":  run_sync(name, a[0], b, c);
          default: stop_with_failure($sformatf("unknown test kind %s in test %s", kind, name));
        endcase
        tests_run++;
      end
    end
    $fclose(fd);

    if (tests_run == 0) begin
      $display("no tests were read from the tests file");
      $display("TESTBENCH FAILED");
      $fatal(1, "empty test list");
    end else begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule

// File: logic/core_top.sv
// core top level between host bridge, controllers, emulator core and scaler
// the settings block feeds the pad mapper and the video shaper

module core_top
  import bridge_pkg::*;
  import av_pkg::*;
#(
  parameter logic [31:0] RESET_HOLD_CYCLES = 32'h0010_0000,
  parameter int          HS_DELAY          = 7,
  parameter int          SYNC_STAGES       = 3
) (
  input  logic         clk_74a,
  input  logic         pll_core_locked,

  ////////////////////////////////////////
  // host bridge
  input  bridge_addr_t bridge_addr,
  input  logic         bridge_wr,
  input  bridge_data_t bridge_wr_data,
  input  logic         bridge_rd,
  output bridge_data_t bridge_rd_data,

  ////////////////////////////////////////
  // settings to the core
  output logic         hide_overscan,
  output edge_mask_t   mask_vid_edges,
  output logic         allow_extra_sprites,
  output palette_t     selected_palette,
  output logic         multitap_enabled,
  output logic         map_y_b,
  output logic         external_reset,

  ////////////////////////////////////////
  // controllers
  input  key_map_t     cont1_key,
  input  key_map_t     cont2_key,
  input  key_map_t     cont3_key,
  input  key_map_t     cont4_key,
  output nes_buttons_t p1_buttons,
  output nes_buttons_t p2_buttons,
  output nes_buttons_t p3_buttons,
  output nes_buttons_t p4_buttons,

  ////////////////////////////////////////
  // core video in, scaler video out
  input  logic         core_hblank,
  input  logic         core_vblank,
  input  logic         core_hsync,
  input  logic         core_vsync,
  input  rgb_t         core_rgb,
  output logic         video_de,
  output logic         video_hs,
  output logic         video_vs,
  output rgb_t         video_rgb
);

  bridge_settings #(
    .RESET_HOLD_CYCLES(RESET_HOLD_CYCLES)
  ) i_settings (
    .clk_74a            (clk_74a),
    .pll_core_locked    (pll_core_locked),
    .bridge_addr        (bridge_addr),
    .bridge_wr          (bridge_wr),
    .bridge_wr_data     (bridge_wr_data),
    .bridge_rd          (bridge_rd),
    .bridge_rd_data     (bridge_rd_data),
    .hide_overscan      (hide_overscan),
    .mask_vid_edges     (mask_vid_edges),
    .allow_extra_sprites(allow_extra_sprites),
    .selected_palette   (selected_palette),
    .multitap_enabled   (multitap_enabled),
    .map_y_b            (map_y_b),
    .external_reset     (external_reset)
  );

  pad_mapper #(
    .SYNC_STAGES(SYNC_STAGES)
  ) i_pads (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .cont1_key       (cont1_key),
    .cont2_key       (cont2_key),
    .cont3_key       (cont3_key),
    .cont4_key       (cont4_key),
    .multitap_enabled(multitap_enabled),
    .map_y_b         (map_y_b),
    .p1_buttons      (p1_buttons),
    .p2_buttons      (p2_buttons),
    .p3_buttons      (p3_buttons),
    .p4_buttons      (p4_buttons)
  );

  video_output_shaper #(
    .HS_DELAY(HS_DELAY)
  ) i_video (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .core_hblank    (core_hblank),
    .core_vblank    (core_vblank),
    .core_hsync     (core_hsync),
    .core_vsync     (core_vsync),
    .core_rgb       (core_rgb),
    .hide_overscan  (hide_overscan),
    .video_de       (video_de),
    .video_hs       (video_hs),
    .video_vs       (video_vs),
    .video_rgb      (video_rgb)
  );

endmodule

// File: logic/video_output_shaper.sv
// registers core video for the scaler
// adds data enable, a delayed one-cycle hsync and a one-cycle vsync
// the first blank cycle after a line carries the slot word

module video_output_shaper
  import av_pkg::*;
#(
  parameter int HS_DELAY = 7
) (
  input  logic clk_74a,
  input  logic pll_core_locked,

  input  logic core_hblank,
  input  logic core_vblank,
  input  logic core_hsync,
  input  logic core_vsync,
  input  rgb_t core_rgb,

  input  logic hide_overscan,

  output logic video_de,
  output logic video_hs,
  output logic video_vs,
  output rgb_t video_rgb
);

  localparam int HS_CNT_W = $clog2(HS_DELAY + 1);
  localparam logic [HS_CNT_W-1:0] HS_LOAD = HS_CNT_W'(HS_DELAY - 1);

  logic                de_prev;
  logic                hs_prev;
  logic                vs_prev;
  logic [HS_CNT_W-1:0] hs_count;

  logic line_active;
  logic line_end;
  logic hs_rise;
  logic vs_rise;
  rgb_t slot_word;

  assign line_active = ~(core_hblank | core_vblank);
  assign line_end    = de_prev & ~line_active;
  assign hs_rise     = core_hsync & ~hs_prev;
  assign vs_rise     = core_vsync & ~vs_prev;

  // scaler slot word, bit 13 is the overscan flag
  assign slot_word   = {10'b0, hide_overscan, 13'b0};

  ////////////////////////////////////////
  // edge history and hsync delay

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      de_prev  <= 1'b0;
      hs_prev  <= 1'b0;
      vs_prev  <= 1'b0;
      hs_count <= '0;
    end else begin
      de_prev <= line_active;
      hs_prev <= core_hsync;
      vs_prev <= core_vsync;

      // a new edge restarts the delay
      if (hs_rise) begin
        hs_count <= HS_LOAD;
      end else if (hs_count != '0) begin
        hs_count <= hs_count - 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // output registers

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      video_de  <= 1'b0;
      video_hs  <= 1'b0;
      video_vs  <= 1'b0;
      video_rgb <= '0;
    end else begin
      video_de <= line_active;
      video_vs <= vs_rise;

      // with a delay of one there is nothing to count
      video_hs <= (HS_DELAY == 1) ? hs_rise
                                  : (hs_count == HS_CNT_W'(1)) && !hs_rise;

      if (line_active) begin
        video_rgb <= core_rgb;
      end else if (line_end) begin
        video_rgb <= slot_word;
      end else begin
        video_rgb <= '0;
      end
    end
  end

  a_vs_single : assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked)
    video_vs |=> !video_vs
  );

  // blanked pixels are black apart from the slot word
  a_blank_black : assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked)
    (!video_de && !$past(line_end)) |-> (video_rgb == '0)
  );

endmodule

// File: logic/pad_mapper.sv
// synchronizes the four controller key bitmaps and builds nes button bytes
// player 1 can swap to y/b for a/b, players 3 and 4 need multitap enabled
// latency from key change to button byte is SYNC_STAGES + 1 cycles

module pad_mapper
  import av_pkg::*;
#(
  parameter int SYNC_STAGES = 3
) (
  input  logic         clk_74a,
  input  logic         pll_core_locked,

  input  key_map_t     cont1_key,
  input  key_map_t     cont2_key,
  input  key_map_t     cont3_key,
  input  key_map_t     cont4_key,

  input  logic         multitap_enabled,
  input  logic         map_y_b,

  output nes_buttons_t p1_buttons,
  output nes_buttons_t p2_buttons,
  output nes_buttons_t p3_buttons,
  output nes_buttons_t p4_buttons
);

  localparam int NUM_PADS = 4;

  key_map_t key_in [NUM_PADS];
  key_map_t key_sync [NUM_PADS][SYNC_STAGES];
  key_map_t key_s [NUM_PADS];

  // nes order with the chosen a and b sources
  function automatic nes_buttons_t to_nes(input key_map_t key, input logic btn_a,
                                          input logic btn_b);
    return {key[KEY_RIGHT], key[KEY_LEFT], key[KEY_DOWN], key[KEY_UP],
            key[KEY_START], key[KEY_SELECT], btn_b, btn_a};
  endfunction

  assign key_in[0] = cont1_key;
  assign key_in[1] = cont2_key;
  assign key_in[2] = cont3_key;
  assign key_in[3] = cont4_key;

  ////////////////////////////////////////
  // input synchronizer

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      for (int p = 0; p < NUM_PADS; p++) begin
        for (int s = 0; s < SYNC_STAGES; s++) begin
          key_sync[p][s] <= '0;
        end
      end
    end else begin
      for (int p = 0; p < NUM_PADS; p++) begin
        key_sync[p][0] <= key_in[p];
        for (int s = 1; s < SYNC_STAGES; s++) begin
          key_sync[p][s] <= key_sync[p][s-1];
        end
      end
    end
  end

  always_comb begin
    for (int p = 0; p < NUM_PADS; p++) begin
      key_s[p] = key_sync[p][SYNC_STAGES-1];
    end
  end

  ////////////////////////////////////////
  // button bytes

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      p1_buttons <= '0;
      p2_buttons <= '0;
      p3_buttons <= '0;
      p4_buttons <= '0;
    end else begin
      // y/b remap puts face_b on a and face_y on b
      p1_buttons <= map_y_b ? to_nes(key_s[0], key_s[0][KEY_FACE_B], key_s[0][KEY_FACE_Y])
                            : to_nes(key_s[0], key_s[0][KEY_FACE_A], key_s[0][KEY_FACE_B]);
      p2_buttons <= to_nes(key_s[1], key_s[1][KEY_FACE_A], key_s[1][KEY_FACE_B]);
      p3_buttons <= multitap_enabled ?
                    to_nes(key_s[2], key_s[2][KEY_FACE_A], key_s[2][KEY_FACE_B]) : '0;
      p4_buttons <= multitap_enabled ?
                    to_nes(key_s[3], key_s[3][KEY_FACE_A], key_s[3][KEY_FACE_B]) : '0;
    end
  end

  // extra pads stay silent one cycle after multitap goes off
  a_multitap_gate : assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked)
    !multitap_enabled |=> (p3_buttons == '0 && p4_buttons == '0)
  );

endmodule

// File: logic/bridge_settings.sv
// core settings written and read back over the host bridge
// writes land on the strobe edge, reads are combinational from the address
// a write to the reset address holds external_reset for RESET_HOLD_CYCLES

module bridge_settings
  import bridge_pkg::*;
#(
  parameter logic [31:0] RESET_HOLD_CYCLES = 32'h0010_0000
) (
  input  logic         clk_74a,
  input  logic         pll_core_locked,

  input  bridge_addr_t bridge_addr,
  input  logic         bridge_wr,
  input  bridge_data_t bridge_wr_data,
  input  logic         bridge_rd,
  output bridge_data_t bridge_rd_data,

  output logic         hide_overscan,
  output edge_mask_t   mask_vid_edges,
  output logic         allow_extra_sprites,
  output palette_t     selected_palette,
  output logic         multitap_enabled,
  output logic         map_y_b,
  output logic         external_reset
);

  logic [31:0] reset_count;

  ////////////////////////////////////////
  // write decode

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      hide_overscan       <= 1'b0;
      mask_vid_edges      <= '0;
      allow_extra_sprites <= 1'b0;
      selected_palette    <= '0;
      multitap_enabled    <= 1'b0;
      map_y_b             <= 1'b0;
      reset_count         <= '0;
    end else begin
      // hold counter runs down unless reloaded below
      if (reset_count != '0) begin
        reset_count <= reset_count - 1'b1;
      end

      if (bridge_wr) begin
        case (bridge_addr)
          ADDR_RESET:         reset_count <= RESET_HOLD_CYCLES;
          ADDR_HIDE_OVERSCAN: hide_overscan <= bridge_wr_data[0];
          ADDR_MASK_EDGES:    mask_vid_edges <= bridge_wr_data[1:0];
          ADDR_EXTRA_SPRITES: allow_extra_sprites <= bridge_wr_data[0];
          ADDR_PALETTE:       selected_palette <= bridge_wr_data[2:0];
          ADDR_MULTITAP:      multitap_enabled <= bridge_wr_data[0];
          ADDR_MAP_Y_B:       map_y_b <= bridge_wr_data[0];
          default:            ;
        endcase
      end
    end
  end

  // high for as long as the count is nonzero
  assign external_reset = (reset_count != '0);

  ////////////////////////////////////////
  // read back

  always_comb begin
    case (bridge_addr)
      ADDR_HIDE_OVERSCAN: bridge_rd_data = {31'b0, hide_overscan};
      ADDR_MASK_EDGES:    bridge_rd_data = {30'b0, mask_vid_edges};
      ADDR_EXTRA_SPRITES: bridge_rd_data = {31'b0, allow_extra_sprites};
      ADDR_PALETTE:       bridge_rd_data = {29'b0, selected_palette};
      ADDR_MULTITAP:      bridge_rd_data = {31'b0, multitap_enabled};
      ADDR_MAP_Y_B:       bridge_rd_data = {31'b0, map_y_b};
      // reset address and unmapped space read as zero
      default:            bridge_rd_data = '0;
    endcase
  end

  // host never issues a read and a write in the same cycle
  a_no_rd_wr_overlap : assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked)
    !(bridge_rd && bridge_wr)
  );

endmodule

// File: logic/av_pkg.sv
// controller key layout, nes button byte and video pixel types
// imported by the pad mapper, the video shaper and the top level

package av_pkg;

  ////////////////////////////////////////
  // controller side

  // one pad's key bitmap as the host delivers it
  typedef logic [15:0] key_map_t;

  // bit positions inside key_map_t
  localparam int KEY_UP = 0;
  localparam int KEY_DOWN = 1;
  localparam int KEY_LEFT = 2;
  localparam int KEY_RIGHT = 3;
  localparam int KEY_FACE_A = 4;
  localparam int KEY_FACE_B = 5;
  // face_x at 6 is not used by the nes
  localparam int KEY_FACE_Y = 7;
  localparam int KEY_SELECT = 14;
  localparam int KEY_START = 15;

  ////////////////////////////////////////
  // core side

  // bit 0 upward: a, b, select, start, up, down, left, right
  typedef logic [7:0] nes_buttons_t;

  // red in [23:16], green in [15:8], blue in [7:0]
  typedef logic [23:0] rgb_t;

endpackage

// File: logic/bridge_pkg.sv
// host bridge address map and setting field types
// imported by the settings block and the top level

package bridge_pkg;

  ////////////////////////////////////////
  // bridge bus words

  typedef logic [31:0] bridge_addr_t;
  typedef logic [31:0] bridge_data_t;

  ////////////////////////////////////////
  // setting fields

  // nes palette choice
  typedef logic [2:0] palette_t;

  // left/right edge masking mode
  typedef logic [1:0] edge_mask_t;

  ////////////////////////////////////////
  // address map

  // write only, starts the timed core reset
  localparam bridge_addr_t ADDR_RESET = 32'h0000_0050;

  // video and ppu options
  localparam bridge_addr_t ADDR_HIDE_OVERSCAN = 32'h0000_0200;
  localparam bridge_addr_t ADDR_MASK_EDGES = 32'h0000_0204;
  localparam bridge_addr_t ADDR_EXTRA_SPRITES = 32'h0000_0208;
  localparam bridge_addr_t ADDR_PALETTE = 32'h0000_020C;

  // controller options
  localparam bridge_addr_t ADDR_MULTITAP = 32'h0000_0300;
  localparam bridge_addr_t ADDR_MAP_Y_B = 32'h0000_0310;

endpackage
